// File: verilog/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

	// Datapath and register file geometry
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;
	localparam int NREGS  = 1 << REG_AW;

	// Field widths carried down the pipe
	localparam int OPC_W    = 7;
	localparam int ALU_FN_W = 4;
	localparam int FN3_W    = 3;
	localparam int MEM_OP_W = 4;
	localparam int SHAMT_W  = 5;

	// Major opcode of LB/LH/LW/LBU/LHU
	localparam logic [OPC_W-1:0] OPC_LOAD = 7'b0000011;

	// Operand B source, IMM doubles as the bubble encoding
	localparam logic [1:0] BSEL_REG   = 2'b00;
	localparam logic [1:0] BSEL_IMM   = 2'b01;
	localparam logic [1:0] BSEL_SHAMT = 2'b10;

	// Cycles from load issue until its result is usable
	localparam int LOAD_LATENCY = 2;
	localparam int LD_CNT_W     = $clog2(LOAD_LATENCY + 1);

endpackage

`default_nettype wire

// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

	localparam int CSR_AW = 12;

	// Machine-mode CSR addresses
	localparam logic [CSR_AW-1:0] CSR_MSTATUS = 12'h300;
	localparam logic [CSR_AW-1:0] CSR_MIE     = 12'h304;
	localparam logic [CSR_AW-1:0] CSR_MTVEC   = 12'h305;
	localparam logic [CSR_AW-1:0] CSR_MEPC    = 12'h341;
	localparam logic [CSR_AW-1:0] CSR_MCAUSE  = 12'h342;
	localparam logic [CSR_AW-1:0] CSR_MIP     = 12'h344;

	// Only U and M are implemented
	typedef enum logic [1:0] {
		PRIV_U = 2'b00,
		PRIV_M = 2'b11
	} priv_mode_t;

	// Field layout of mstatus, unused bits kept as reserved
	typedef struct packed {
		logic [18:0] wpri_hi;
		logic [1:0]  mpp;
		logic [2:0]  wpri_mid;
		logic        mpie;
		logic [2:0]  wpri_lo;
		logic        mie;
		logic [2:0]  wpri_uie;
	} mstatus_fields_t;

	// Raw word for the CSR port, fields for trap and mret
	typedef union packed {
		logic [31:0]     raw;
		mstatus_fields_t f;
	} mstatus_u;

	// Interrupt enable/pending bit positions
	localparam int MIE_MTIE_BIT = 7;
	localparam int MIE_MEIE_BIT = 11;

endpackage

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
	import rv_pipe_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              we,
	input  logic [REG_AW-1:0] waddr,
	input  logic [XLEN-1:0]   wdata,
	input  logic [REG_AW-1:0] raddr_a,
	input  logic [REG_AW-1:0] raddr_b,
	output logic [XLEN-1:0]   rdata_a,
	output logic [XLEN-1:0]   rdata_b
);

	// x0 has no storage
	logic [XLEN-1:0] mem [1:NREGS-1];

	// Read value seen at this edge, including a write in flight
	function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
		logic [XLEN-1:0] val;
		if (addr == '0)
			val = '0;
		else if (we && waddr == addr)
			val = wdata;
		else
			val = mem[addr];
		return val;
	endfunction

	always_ff @(posedge clk)
	begin
		if (we && waddr != '0)
			mem[waddr] <= wdata;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rdata_a <= '0;
			rdata_b <= '0;
		end
		else
		begin
			rdata_a <= read_port(raddr_a);
			rdata_b <= read_port(raddr_b);
		end
	end

endmodule

`default_nettype wire

// File: verilog/hazard_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_scoreboard
	import rv_pipe_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              valid3,
	input  logic              we3,
	input  logic [OPC_W-1:0]  opcode3,
	input  logic [REG_AW-1:0] rd3,
	input  logic [REG_AW-1:0] rs1,
	input  logic [REG_AW-1:0] rs2,
	input  logic              bjtaken,
	input  logic              exception,
	output logic              stall,
	output logic              kill
);

	// Cycles left until each register's load data is usable
	logic [LD_CNT_W-1:0] ld_cnt [NREGS];
	logic                kill_q;
	logic                rs1_busy;
	logic                rs2_busy;
	logic                ld_issue;

	// Flush covers the redirect cycle and one more
	assign kill = bjtaken | exception | kill_q;

	assign rs1_busy = (rs1 != '0) && (ld_cnt[rs1] != '0);
	assign rs2_busy = (rs2 != '0) && (ld_cnt[rs2] != '0);
	assign stall    = valid3 && (rs1_busy || rs2_busy) && !kill;

	// Load actually leaves decode this cycle
	assign ld_issue = valid3 && we3 && !stall && !kill &&
		(opcode3 == OPC_LOAD) && (rd3 != '0);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			kill_q <= 1'b0;
		else
			kill_q <= bjtaken | exception;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < NREGS; i++)
				ld_cnt[i] <= '0;
		end
		else if (exception)
		begin
			// Loads in flight are squashed
			for (int i = 0; i < NREGS; i++)
				ld_cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < NREGS; i++)
			begin
				if (ld_issue && rd3 == REG_AW'(i))
					ld_cnt[i] <= LD_CNT_W'(LOAD_LATENCY);
				else if (ld_cnt[i] != '0)
					ld_cnt[i] <= ld_cnt[i] - LD_CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
	import rv_pipe_pkg::*;
	import csr_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              csr_we,
	input  logic [CSR_AW-1:0] csr_wb_addr,
	input  logic [XLEN-1:0]   csr_wb,
	input  logic [CSR_AW-1:0] csr_raddr,
	input  logic              exception_pending,
	input  logic [XLEN-1:0]   cause,
	input  logic [XLEN-1:0]   pc_exc,
	input  logic              m_ret,
	input  logic              timer_irq,
	input  logic              ext_irq,
	output logic [XLEN-1:0]   csr_data,
	output logic [XLEN-1:0]   epc,
	output priv_mode_t        current_mode,
	output logic              m_tie,
	output logic              m_eie,
	output logic              m_timer,
	output logic              m_ext
);

	mstatus_u        mstatus;
	mstatus_u        mstatus_wr;
	logic [XLEN-1:0] mie_q;
	logic [XLEN-1:0] mtvec_q;
	logic [XLEN-1:0] mepc_q;
	logic [XLEN-1:0] mcause_q;
	logic [XLEN-1:0] mip_w;

	// Software writes, mpp only keeps legal modes
	always_comb
	begin
		mstatus_wr.raw = csr_wb;
		if (mstatus_wr.f.mpp != PRIV_M)
			mstatus_wr.f.mpp = PRIV_U;
	end

	// Pending bits mirror the interrupt lines
	always_comb
	begin
		mip_w = '0;
		mip_w[MIE_MTIE_BIT] = timer_irq;
		mip_w[MIE_MEIE_BIT] = ext_irq;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mstatus.raw  <= '0;
			current_mode <= PRIV_M;
		end
		else if (exception_pending)
		begin
			mstatus.f.mpie <= mstatus.f.mie;
			mstatus.f.mie  <= 1'b0;
			mstatus.f.mpp  <= current_mode;
			current_mode   <= PRIV_M;
		end
		else if (m_ret)
		begin
			current_mode   <= priv_mode_t'(mstatus.f.mpp);
			mstatus.f.mie  <= mstatus.f.mpie;
			mstatus.f.mpie <= 1'b1;
			mstatus.f.mpp  <= PRIV_U;
		end
		else if (csr_we && csr_wb_addr == CSR_MSTATUS)
			mstatus.raw <= mstatus_wr.raw;
	end

	// Trap capture beats a software write in the same cycle
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mepc_q   <= '0;
			mcause_q <= '0;
		end
		else if (exception_pending)
		begin
			mepc_q   <= pc_exc;
			mcause_q <= cause;
		end
		else if (csr_we)
		begin
			if (csr_wb_addr == CSR_MEPC)
				mepc_q <= csr_wb;
			if (csr_wb_addr == CSR_MCAUSE)
				mcause_q <= csr_wb;
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mie_q   <= '0;
			mtvec_q <= '0;
		end
		else if (csr_we)
		begin
			if (csr_wb_addr == CSR_MIE)
				mie_q <= csr_wb;
			if (csr_wb_addr == CSR_MTVEC)
				mtvec_q <= csr_wb;
		end
	end

	always_comb
	begin
		case (csr_raddr)
			CSR_MSTATUS: csr_data = mstatus.raw;
			CSR_MIE:     csr_data = mie_q;
			CSR_MIP:     csr_data = mip_w;
			CSR_MTVEC:   csr_data = mtvec_q;
			CSR_MEPC:    csr_data = mepc_q;
			CSR_MCAUSE:  csr_data = mcause_q;
			default:     csr_data = '0;
		endcase
	end

	assign epc   = mepc_q;
	assign m_tie = mie_q[MIE_MTIE_BIT];
	assign m_eie = mie_q[MIE_MEIE_BIT];

	// Taken only with the global enable set
	assign m_timer = timer_irq & m_tie & mstatus.f.mie;
	assign m_ext   = ext_irq & m_eie & mstatus.f.mie;

endmodule

`default_nettype wire

// File: verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage
	import rv_pipe_pkg::*;
	import csr_pkg::*;
(
	input  logic                clk,
	input  logic                nrst,
	// Decode
	input  logic                valid3,
	input  logic                we3,
	input  logic [REG_AW-1:0]   rd3,
	input  logic [REG_AW-1:0]   rs1,
	input  logic [REG_AW-1:0]   rs2,
	input  logic [OPC_W-1:0]    opcode3,
	input  logic [ALU_FN_W-1:0] alu_fn3,
	input  logic [FN3_W-1:0]    fn3,
	input  logic [1:0]          b_sel3,
	input  logic [XLEN-1:0]     i_imm3,
	input  logic [SHAMT_W-1:0]  shamt3,
	input  logic [MEM_OP_W-1:0] mem_op3,
	input  logic [XLEN-1:0]     pc3,
	input  logic                csr_we3,
	input  logic [CSR_AW-1:0]   csr_addr3,
	input  logic                ecall3,
	input  logic                illegal_instr3,
	input  logic                mret3,
	// Execute
	output logic                valid4,
	output logic                we4,
	output logic [REG_AW-1:0]   rd4,
	output logic [ALU_FN_W-1:0] alu_fn4,
	output logic [FN3_W-1:0]    fn4,
	output logic [MEM_OP_W-1:0] mem_op4,
	output logic [XLEN-1:0]     pc4,
	output logic                csr_we4,
	output logic [CSR_AW-1:0]   csr_addr4,
	output logic                ecall4,
	output logic                illegal_instr4,
	output logic                mret4,
	output logic [XLEN-1:0]     op_a,
	output logic [XLEN-1:0]     op_b,
	output logic [XLEN-1:0]     csr_data,
	// Commit
	input  logic                we6,
	input  logic [REG_AW-1:0]   rdaddr6,
	input  logic [XLEN-1:0]     wb6,
	input  logic                csr_we6,
	input  logic [CSR_AW-1:0]   csr_wb_addr,
	input  logic [XLEN-1:0]     csr_wb,
	input  logic                exception_pending,
	input  logic [XLEN-1:0]     cause,
	input  logic [XLEN-1:0]     pc_exc,
	input  logic                m_ret,
	// Frontend and interrupts
	input  logic                bjtaken,
	input  logic                exception,
	input  logic                timer_irq,
	input  logic                ext_irq,
	output logic                stall,
	output logic [XLEN-1:0]     epc,
	output priv_mode_t          current_mode,
	output logic                m_tie,
	output logic                m_eie,
	output logic                m_timer,
	output logic                m_ext
);

	logic                kill;
	logic [XLEN-1:0]     rf_a;
	logic [XLEN-1:0]     rf_b;
	logic [1:0]          b_sel4;
	logic [XLEN-1:0]     i_imm4;
	logic [SHAMT_W-1:0]  shamt4;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			valid4         <= 1'b0;
			we4            <= 1'b0;
			rd4            <= '0;
			alu_fn4        <= '0;
			fn4            <= '0;
			mem_op4        <= '0;
			csr_we4        <= 1'b0;
			ecall4         <= 1'b0;
			illegal_instr4 <= 1'b0;
			mret4          <= 1'b0;
			b_sel4         <= '0;
			i_imm4         <= '0;
			pc4            <= '0;
			csr_addr4      <= '0;
			shamt4         <= '0;
		end
		else
		begin
			// Payload follows decode even in a bubble
			pc4       <= pc3;
			csr_addr4 <= csr_addr3;
			shamt4    <= shamt3;
			if (stall || kill)
			begin
				valid4         <= 1'b0;
				we4            <= 1'b0;
				rd4            <= '0;
				alu_fn4        <= '0;
				fn4            <= '0;
				mem_op4        <= '0;
				csr_we4        <= 1'b0;
				ecall4         <= 1'b0;
				illegal_instr4 <= 1'b0;
				mret4          <= 1'b0;
				b_sel4         <= BSEL_IMM;
				i_imm4         <= '0;
			end
			else
			begin
				valid4         <= valid3;
				we4            <= we3;
				rd4            <= rd3;
				alu_fn4        <= alu_fn3;
				fn4            <= fn3;
				mem_op4        <= mem_op3;
				csr_we4        <= csr_we3;
				ecall4         <= ecall3;
				illegal_instr4 <= illegal_instr3;
				mret4          <= mret3;
				b_sel4         <= b_sel3;
				i_imm4         <= i_imm3;
			end
		end
	end

	// Read ports sampled at the same edge as the pipe registers
	regfile u_regfile (
		.clk     (clk),
		.nrst    (nrst),
		.we      (we6),
		.waddr   (rdaddr6),
		.wdata   (wb6),
		.raddr_a (rs1),
		.raddr_b (rs2),
		.rdata_a (rf_a),
		.rdata_b (rf_b)
	);

	hazard_scoreboard u_hazard_scoreboard (
		.clk       (clk),
		.nrst      (nrst),
		.valid3    (valid3),
		.we3       (we3),
		.opcode3   (opcode3),
		.rd3       (rd3),
		.rs1       (rs1),
		.rs2       (rs2),
		.bjtaken   (bjtaken),
		.exception (exception),
		.stall     (stall),
		.kill      (kill)
	);

	csr_regfile u_csr_regfile (
		.clk               (clk),
		.nrst              (nrst),
		.csr_we            (csr_we6),
		.csr_wb_addr       (csr_wb_addr),
		.csr_wb            (csr_wb),
		.csr_raddr         (csr_addr4),
		.exception_pending (exception_pending),
		.cause             (cause),
		.pc_exc            (pc_exc),
		.m_ret             (m_ret),
		.timer_irq         (timer_irq),
		.ext_irq           (ext_irq),
		.csr_data          (csr_data),
		.epc               (epc),
		.current_mode      (current_mode),
		.m_tie             (m_tie),
		.m_eie             (m_eie),
		.m_timer           (m_timer),
		.m_ext             (m_ext)
	);

	assign op_a = rf_a;

	// Operand B source
	always_comb
	begin
		case (b_sel4)
			BSEL_REG:   op_b = rf_b;
			BSEL_IMM:   op_b = i_imm4;
			BSEL_SHAMT: op_b = {{(XLEN-SHAMT_W){1'b0}}, shamt4};
			default:    op_b = rf_b;
		endcase
	end

endmodule

`default_nettype wire

// File: testbench/issue_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage_chk
	import csr_pkg::*;
(
	input logic       clk,
	input logic       nrst,
	input logic       stall,
	input logic       kill,
	input logic       valid4,
	input logic       we4,
	input logic       csr_we4,
	input logic       bjtaken,
	input logic       exception,
	input priv_mode_t current_mode
);

	a_stall_kill_excl: assert property (@(posedge clk) disable iff (!nrst)
		!(stall && kill))
		else $error("stall and kill are high together");

	// An empty slot must not write anything
	a_bubble_no_write: assert property (@(posedge clk) disable iff (!nrst)
		!valid4 |-> (!we4 && !csr_we4))
		else $error("write enable set in an invalid stage-4 slot");

	a_legal_mode: assert property (@(posedge clk) disable iff (!nrst)
		current_mode inside {PRIV_U, PRIV_M})
		else $error("current_mode holds an unimplemented privilege level");

	// Flush shadow lasts one extra cycle
	a_kill_shadow: assert property (@(posedge clk) disable iff (!nrst)
		(bjtaken || exception) |=> kill)
		else $error("kill did not persist after a redirect");

endmodule

bind issue_stage issue_stage_chk u_issue_stage_chk (
	.clk          (clk),
	.nrst         (nrst),
	.stall        (stall),
	.kill         (kill),
	.valid4       (valid4),
	.we4          (we4),
	.csr_we4      (csr_we4),
	.bjtaken      (bjtaken),
	.exception    (exception),
	.current_mode (current_mode)
);

`default_nettype wire

// File: testbench/tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage
	import rv_pipe_pkg::*;
	import csr_pkg::*;
();

	logic                clk;
	logic                nrst;
	logic                valid3;
	logic                we3;
	logic [REG_AW-1:0]   rd3;
	logic [REG_AW-1:0]   rs1;
	logic [REG_AW-1:0]   rs2;
	logic [OPC_W-1:0]    opcode3;
	logic [ALU_FN_W-1:0] alu_fn3;
	logic [FN3_W-1:0]    fn3;
	logic [1:0]          b_sel3;
	logic [XLEN-1:0]     i_imm3;
	logic [SHAMT_W-1:0]  shamt3;
	logic [MEM_OP_W-1:0] mem_op3;
	logic [XLEN-1:0]     pc3;
	logic                csr_we3;
	logic [CSR_AW-1:0]   csr_addr3;
	logic                ecall3;
	logic                illegal_instr3;
	logic                mret3;
	logic                valid4;
	logic                we4;
	logic [REG_AW-1:0]   rd4;
	logic [ALU_FN_W-1:0] alu_fn4;
	logic [FN3_W-1:0]    fn4;
	logic [MEM_OP_W-1:0] mem_op4;
	logic [XLEN-1:0]     pc4;
	logic                csr_we4;
	logic [CSR_AW-1:0]   csr_addr4;
	logic                ecall4;
	logic                illegal_instr4;
	logic                mret4;
	logic [XLEN-1:0]     op_a;
	logic [XLEN-1:0]     op_b;
	logic [XLEN-1:0]     csr_data;
	logic                we6;
	logic [REG_AW-1:0]   rdaddr6;
	logic [XLEN-1:0]     wb6;
	logic                csr_we6;
	logic [CSR_AW-1:0]   csr_wb_addr;
	logic [XLEN-1:0]     csr_wb;
	logic                exception_pending;
	logic [XLEN-1:0]     cause;
	logic [XLEN-1:0]     pc_exc;
	logic                m_ret;
	logic                bjtaken;
	logic                exception;
	logic                timer_irq;
	logic                ext_irq;
	logic                stall;
	logic [XLEN-1:0]     epc;
	priv_mode_t          current_mode;
	logic                m_tie;
	logic                m_eie;
	logic                m_timer;
	logic                m_ext;

	logic [15:0]     lfsr;
	logic [XLEN-1:0] rf_model [NREGS];
	string           test_name;

	issue_stage u_issue_stage (.*);

	always #10 clk = ~clk;

	// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [XLEN-1:0] rand_bits(input int n);
		logic [XLEN-1:0] val;
		logic            fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val  = {val[XLEN-2:0], lfsr[0]};
			fb   = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];
			lfsr = {fb, lfsr[15:1]};
		end
		return val;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_word(input string what, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		assert (act === exp)
		else
		begin
			$display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, act);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		assert (act === exp)
		else
		begin
			$display("[FAIL] %s: %s expected %b, actual %b", test_name, what, exp, act);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout in test %s: %s", test_name, what);
		$display("TB FAILED");
		$fatal(1, "timeout");
	endtask

	task automatic clear_decode();
		valid3         = 1'b0;
		we3            = 1'b0;
		rd3            = '0;
		rs1            = '0;
		rs2            = '0;
		opcode3        = '0;
		alu_fn3        = '0;
		fn3            = '0;
		b_sel3         = BSEL_REG;
		i_imm3         = '0;
		shamt3         = '0;
		mem_op3        = '0;
		pc3            = '0;
		csr_we3        = 1'b0;
		csr_addr3      = '0;
		ecall3         = 1'b0;
		illegal_instr3 = 1'b0;
		mret3          = 1'b0;
	endtask

	task automatic clear_commit();
		we6               = 1'b0;
		rdaddr6           = '0;
		wb6               = '0;
		csr_we6           = 1'b0;
		csr_wb_addr       = '0;
		csr_wb            = '0;
		exception_pending = 1'b0;
		cause             = '0;
		pc_exc            = '0;
		m_ret             = 1'b0;
		bjtaken           = 1'b0;
		exception         = 1'b0;
		timer_irq         = 1'b0;
		ext_irq           = 1'b0;
	endtask

	task automatic drive_instr(input logic [OPC_W-1:0] opc, input logic [REG_AW-1:0] rd,
		input logic [REG_AW-1:0] a, input logic [REG_AW-1:0] b, input logic [1:0] bsel);
		valid3  = 1'b1;
		we3     = 1'b1;
		opcode3 = opc;
		rd3     = rd;
		rs1     = a;
		rs2     = b;
		b_sel3  = bsel;
		alu_fn3 = 4'h1;
		fn3     = 3'h5;
		mem_op3 = 4'h2;
	endtask

	task automatic rf_write(input logic [REG_AW-1:0] addr, input logic [XLEN-1:0] data);
		we6     = 1'b1;
		rdaddr6 = addr;
		wb6     = data;
		tick();
		we6 = 1'b0;
		if (addr != '0)
			rf_model[addr] = data;
	endtask

	task automatic csr_write(input logic [CSR_AW-1:0] addr, input logic [XLEN-1:0] data);
		csr_we6     = 1'b1;
		csr_wb_addr = addr;
		csr_wb      = data;
		tick();
		csr_we6 = 1'b0;
	endtask

	task automatic csr_read_check(input string what, input logic [CSR_AW-1:0] addr,
		input logic [XLEN-1:0] exp);
		csr_addr3 = addr;
		tick();
		check_word({what, " addr"}, 32'(addr), 32'(csr_addr4));
		check_word(what, exp, csr_data);
	endtask

	// Empty slot with B select IMM and a zero immediate
	task automatic check_bubble();
		check_bit("bubble valid4", 1'b0, valid4);
		check_bit("bubble we4", 1'b0, we4);
		check_bit("bubble csr_we4", 1'b0, csr_we4);
		check_bit("bubble ecall4", 1'b0, ecall4);
		check_bit("bubble illegal_instr4", 1'b0, illegal_instr4);
		check_bit("bubble mret4", 1'b0, mret4);
		check_word("bubble rd4", '0, 32'(rd4));
		check_word("bubble alu_fn4", '0, 32'(alu_fn4));
		check_word("bubble fn4", '0, 32'(fn4));
		check_word("bubble op_b", '0, op_b);
	endtask

	task automatic test_reset();
		test_name = "reset";
		nrst = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		nrst = 1'b1;
		check_bit("valid4", 1'b0, valid4);
		check_bit("stall", 1'b0, stall);
		check_bit("we4", 1'b0, we4);
		check_bit("csr_we4", 1'b0, csr_we4);
		check_bit("m_timer", 1'b0, m_timer);
		check_bit("m_ext", 1'b0, m_ext);
		check_word("op_a", '0, op_a);
		check_word("current_mode", 32'(PRIV_M), 32'(current_mode));
	endtask

	task automatic test_operands();
		logic [XLEN-1:0]    imm;
		logic [XLEN-1:0]    data;
		logic [SHAMT_W-1:0] sh;
		test_name = "operands";
		for (int r = 1; r <= 4; r++)
			rf_write(REG_AW'(r), rand_bits(XLEN));
		drive_instr(7'b0110011, 5'd5, 5'd1, 5'd2, BSEL_REG);
		pc3 = 32'h0000_0400;
		tick();
		check_bit("valid4", 1'b1, valid4);
		check_word("rd4", 32'd5, 32'(rd4));
		check_word("pc4", 32'h0000_0400, pc4);
		check_word("alu_fn4", 32'h1, 32'(alu_fn4));
		check_word("fn4", 32'h5, 32'(fn4));
		check_word("mem_op4", 32'h2, 32'(mem_op4));
		check_word("op_a x1", rf_model[1], op_a);
		check_word("op_b x2", rf_model[2], op_b);
		imm = rand_bits(XLEN);
		drive_instr(7'b0010011, 5'd5, 5'd3, 5'd4, BSEL_IMM);
		i_imm3 = imm;
		tick();
		check_word("op_a x3", rf_model[3], op_a);
		check_word("op_b imm", imm, op_b);
		sh = SHAMT_W'(rand_bits(SHAMT_W));
		drive_instr(7'b0010011, 5'd5, 5'd0, 5'd4, BSEL_SHAMT);
		shamt3 = sh;
		tick();
		check_word("op_a x0", '0, op_a);
		check_word("op_b shamt", 32'(sh), op_b);
		// x0 ignores commit writes
		rf_write(5'd0, rand_bits(XLEN));
		drive_instr(7'b0110011, 5'd5, 5'd0, 5'd0, BSEL_REG);
		tick();
		check_word("op_a x0 after write", '0, op_a);
		check_word("op_b x0 after write", '0, op_b);
		data = rand_bits(XLEN);
		drive_instr(7'b0110011, 5'd5, 5'd2, 5'd2, BSEL_REG);
		we6     = 1'b1;
		rdaddr6 = 5'd2;
		wb6     = data;
		tick();
		we6 = 1'b0;
		rf_model[2] = data;
		check_word("op_a write-through", data, op_a);
		check_word("op_b write-through", data, op_b);
		clear_decode();
	endtask

	task automatic test_load_use();
		int   stalls;
		int   guard;
		logic done;
		test_name = "load_use";
		drive_instr(OPC_LOAD, 5'd6, 5'd1, 5'd0, BSEL_IMM);
		i_imm3 = 32'h0000_0010;
		tick();
		check_bit("load valid4", 1'b1, valid4);
		check_word("load rd4", 32'd6, 32'(rd4));
		check_word("load op_b", 32'h0000_0010, op_b);
		drive_instr(7'b0110011, 5'd7, 5'd6, 5'd2, BSEL_REG);
		stalls = 0;
		guard  = 0;
		done   = 1'b0;
		while (!done && guard <= LOAD_LATENCY + 4)
		begin
			#1;
			if (stall)
			begin
				stalls++;
				tick();
				check_bubble();
			end
			else
			begin
				tick();
				done = 1'b1;
			end
			guard++;
		end
		if (!done)
			timeout_fail("stall never released after load");
		check_word("stall cycles", 32'(LOAD_LATENCY), 32'(stalls));
		check_bit("dependent valid4", 1'b1, valid4);
		check_word("dependent rd4", 32'd7, 32'(rd4));
		// Second load followed by a consumer that does not touch it
		drive_instr(OPC_LOAD, 5'd8, 5'd1, 5'd0, BSEL_IMM);
		tick();
		drive_instr(7'b0110011, 5'd9, 5'd1, 5'd2, BSEL_REG);
		#1;
		check_bit("independent stall", 1'b0, stall);
		tick();
		check_bit("independent valid4", 1'b1, valid4);
		check_word("independent rd4", 32'd9, 32'(rd4));
		clear_decode();
		repeat (LOAD_LATENCY) tick();
	endtask

	task automatic test_flush();
		test_name = "flush";
		// Load in flight so the redirect has a stall to mask
		drive_instr(OPC_LOAD, 5'd11, 5'd1, 5'd0, BSEL_IMM);
		tick();
		drive_instr(7'b0110011, 5'd10, 5'd11, 5'd2, BSEL_REG);
		csr_we3        = 1'b1;
		ecall3         = 1'b1;
		illegal_instr3 = 1'b1;
		mret3          = 1'b1;
		bjtaken = 1'b1;
		#1;
		check_bit("stall under kill", 1'b0, stall);
		tick();
		bjtaken = 1'b0;
		check_bubble();
		tick();
		check_bubble();
		tick();
		check_bit("resume valid4", 1'b1, valid4);
		check_word("resume rd4", 32'd10, 32'(rd4));
		check_bit("resume csr_we4", 1'b1, csr_we4);
		check_bit("resume ecall4", 1'b1, ecall4);
		check_bit("resume illegal_instr4", 1'b1, illegal_instr4);
		check_bit("resume mret4", 1'b1, mret4);
		clear_decode();
	endtask

	task automatic test_csr();
		logic [XLEN-1:0] mtvec_val;
		logic [XLEN-1:0] mie_val;
		logic [XLEN-1:0] junk;
		test_name = "csr";
		mtvec_val = rand_bits(XLEN);
		mie_val   = rand_bits(XLEN);
		junk      = rand_bits(XLEN);
		csr_write(CSR_MTVEC, mtvec_val);
		csr_write(CSR_MIE, mie_val);
		// mscratch and a custom address are not implemented
		csr_write(12'h340, junk);
		csr_write(12'h7C0, junk);
		check_bit("m_tie", mie_val[MIE_MTIE_BIT], m_tie);
		check_bit("m_eie", mie_val[MIE_MEIE_BIT], m_eie);
		csr_read_check("mtvec", CSR_MTVEC, mtvec_val);
		csr_read_check("mie", CSR_MIE, mie_val);
		csr_read_check("mscratch", 12'h340, '0);
		csr_read_check("custom", 12'h7C0, '0);
		mie_val = ~mie_val;
		csr_write(CSR_MIE, mie_val);
		check_bit("m_tie inverted", mie_val[MIE_MTIE_BIT], m_tie);
		check_bit("m_eie inverted", mie_val[MIE_MEIE_BIT], m_eie);
	endtask

	task automatic test_trap();
		logic [XLEN-1:0] cause_val;
		logic [XLEN-1:0] pc_val;
		test_name = "trap";
		csr_write(CSR_MSTATUS, 32'h0000_0008);
		csr_write(CSR_MIE, (32'd1 << MIE_MTIE_BIT) | (32'd1 << MIE_MEIE_BIT));
		timer_irq = 1'b1;
		tick();
		check_bit("m_timer enabled", 1'b1, m_timer);
		check_bit("m_ext idle", 1'b0, m_ext);
		// Machine timer interrupt cause
		cause_val = {1'b1, 31'd7};
		pc_val    = rand_bits(XLEN) & ~32'h3;
		exception_pending = 1'b1;
		cause             = cause_val;
		pc_exc            = pc_val;
		csr_addr3         = CSR_MCAUSE;
		tick();
		exception_pending = 1'b0;
		check_word("epc", pc_val, epc);
		check_word("mcause", cause_val, csr_data);
		check_bit("m_timer masked", 1'b0, m_timer);
		check_word("mode after trap", 32'(PRIV_M), 32'(current_mode));
		// mpie=1, mie=0, mpp=M
		csr_read_check("mstatus after trap", CSR_MSTATUS, 32'h0000_1880);
		m_ret = 1'b1;
		tick();
		m_ret = 1'b0;
		check_word("mode from mpp", 32'(PRIV_M), 32'(current_mode));
		check_word("mstatus after mret", 32'h0000_0088, csr_data);
		check_bit("m_timer restored", 1'b1, m_timer);
		// mpp now holds U
		m_ret = 1'b1;
		tick();
		m_ret = 1'b0;
		check_word("mode after second mret", 32'(PRIV_U), 32'(current_mode));
		timer_irq = 1'b0;
		ext_irq   = 1'b1;
		tick();
		check_bit("m_ext enabled", 1'b1, m_ext);
		check_bit("m_timer idle", 1'b0, m_timer);
		ext_irq = 1'b0;
	endtask

	initial
	begin
		clk  = 1'b0;
		nrst = 1'b0;
		lfsr = 16'd44291;
		clear_decode();
		clear_commit();
		test_reset();
		test_operands();
		test_load_use();
		test_flush();
		test_csr();
		test_trap();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/rv_pipe_pkg.sv
verilog/csr_pkg.sv
verilog/regfile.sv
verilog/hazard_scoreboard.sv
verilog/csr_regfile.sv
verilog/issue_stage.sv
testbench/issue_stage_chk.sv
testbench/tb_issue_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_issue_stage
FILELIST  ?= filelist.f

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

check:
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
